//--- verilog/bossPkg.sv
package bossPkg;

    // pixel and position coordinates share one width across the subsystem.
    localparam int coordWidth = 11;

    // visible screen area.
    localparam int screenWidth = 640;
    localparam int screenHeight = 480;

    // the boss occupies a square box of this edge.
    localparam int spriteSize = 64;

    // missile box.
    localparam int missileWidth = 4;
    localparam int missileHeight = 8;

    // two-colour boss pattern; the core is the centred 16x16 square.
    localparam logic [7:0] bodyColor = 8'hE0;
    localparam logic [7:0] coreColor = 8'h1C;
    localparam logic [7:0] missileColor = 8'hD0;

    // indices into the 7-bit collision vector.
    localparam int hitBossBit = 0;
    localparam int hitMissileBitA = 2;
    localparam int hitMissileBitB = 4;

    typedef enum logic [1:0] {
        alive,
        dying,
        gone
    } bossStateT;

endpackage

//--- verilog/bossMotion.sv
module bossMotion #(
    parameter int initialX = 300,
    parameter int initialY = 200,
    parameter int xSpeed = 8,
    parameter int ySpeed = -2,
    parameter int deathFrames = 10
) (
    input  logic clk,
    input  logic rstN,
    input  logic frameTick,
    input  logic [6:0] collision,
    input  logic bossDR,
    output logic [bossPkg::coordWidth-1:0] topLeftX,
    output logic [bossPkg::coordWidth-1:0] topLeftY,
    output logic alive,
    output logic visible
);

    localparam int coordWidth = bossPkg::coordWidth;
    localparam int stepWidth = coordWidth + 2;
    localparam int maxX = bossPkg::screenWidth - bossPkg::spriteSize;
    localparam int maxY = bossPkg::screenHeight - bossPkg::spriteSize;
    localparam int countWidth = (deathFrames > 1) ? $clog2(deathFrames + 1) : 1;

    bossPkg::bossStateT state;
    logic [countWidth-1:0] frameCount;
    logic signed [coordWidth-1:0] xVel;
    logic signed [coordWidth-1:0] yVel;
    logic signed [stepWidth-1:0] stepX;
    logic signed [stepWidth-1:0] stepY;
    logic bossHit;
    logic moving;

    // extra bits let a step below zero or past the limit be seen before clamping.
    assign stepX = $signed({2'b00, topLeftX}) + xVel;
    assign stepY = $signed({2'b00, topLeftY}) + yVel;

    assign bossHit = collision[bossPkg::hitBossBit] && bossDR && state == bossPkg::alive;
    // a hit freezes the boss on the very cycle it lands.
    assign moving = frameTick && state == bossPkg::alive && !bossHit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            topLeftX <= coordWidth'(initialX);
            topLeftY <= coordWidth'(initialY);
            xVel <= coordWidth'(xSpeed);
            yVel <= coordWidth'(ySpeed);
        end else if (moving) begin
            if (stepX < 0) begin
                topLeftX <= '0;
                xVel <= -xVel;
            end else if (stepX > maxX) begin
                topLeftX <= coordWidth'(maxX);
                xVel <= -xVel;
            end else begin
                topLeftX <= stepX[coordWidth-1:0];
            end
            if (stepY < 0) begin
                topLeftY <= '0;
                yVel <= -yVel;
            end else if (stepY > maxY) begin
                topLeftY <= coordWidth'(maxY);
                yVel <= -yVel;
            end else begin
                topLeftY <= stepY[coordWidth-1:0];
            end
        end
    end

    // life cycle; dying lasts deathFrames frame steps before the sprite goes.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= bossPkg::alive;
            frameCount <= '0;
        end else begin
            case (state)
                bossPkg::alive: begin
                    if (bossHit) begin
                        state <= bossPkg::dying;
                        frameCount <= '0;
                    end
                end
                bossPkg::dying: begin
                    if (frameTick) begin
                        if (frameCount == countWidth'(deathFrames - 1)) begin
                            state <= bossPkg::gone;
                        end else begin
                            frameCount <= frameCount + 1'b1;
                        end
                    end
                end
                default: state <= bossPkg::gone;
            endcase
        end
    end

    assign alive = (state == bossPkg::alive);
    assign visible = (state != bossPkg::gone);

    positionInRange: assert property (@(posedge clk) disable iff (!rstN)
        topLeftX <= maxX && topLeftY <= maxY);

    goneIsFinal: assert property (@(posedge clk) disable iff (!rstN)
        state == bossPkg::gone |=> state == bossPkg::gone);

endmodule

//--- verilog/bossSprite.sv
module bossSprite (
    input  logic clk,
    input  logic rstN,
    input  logic [bossPkg::coordWidth-1:0] pixelX,
    input  logic [bossPkg::coordWidth-1:0] pixelY,
    input  logic [bossPkg::coordWidth-1:0] topLeftX,
    input  logic [bossPkg::coordWidth-1:0] topLeftY,
    input  logic visible,
    output logic bossDR,
    output logic [7:0] bossRGB
);

    localparam int coreSize = 16;
    localparam int coreLow = (bossPkg::spriteSize - coreSize) / 2;
    localparam int coreHigh = coreLow + coreSize;

    logic [bossPkg::coordWidth-1:0] offsetX;
    logic [bossPkg::coordWidth-1:0] offsetY;
    logic inBox;
    logic inCore;

    // offsets are only meaningful when the pixel is right of and below the corner.
    assign offsetX = pixelX - topLeftX;
    assign offsetY = pixelY - topLeftY;

    assign inBox = pixelX >= topLeftX && offsetX < bossPkg::spriteSize &&
                   pixelY >= topLeftY && offsetY < bossPkg::spriteSize;

    assign inCore = offsetX >= coreLow && offsetX < coreHigh &&
                    offsetY >= coreLow && offsetY < coreHigh;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bossDR <= 1'b0;
        end else begin
            bossDR <= inBox && visible;
        end
    end

    always_ff @(posedge clk) begin
        bossRGB <= inCore ? bossPkg::coreColor : bossPkg::bodyColor;
    end

endmodule

//--- verilog/missileLauncher.sv
module missileLauncher #(
    parameter int slotCount = 4,
    parameter int cooldownFrames = 90
) (
    input  logic clk,
    input  logic rstN,
    input  logic frameTick,
    input  logic alive,
    input  logic [slotCount-1:0] slotBusy,
    output logic [slotCount-1:0] launch
);

    localparam int countWidth = (cooldownFrames > 1) ? $clog2(cooldownFrames + 1) : 1;

    logic [countWidth-1:0] cooldown;
    logic [slotCount-1:0] freeOneHot;
    logic ready;

    // lowest-index free slot wins.
    always_comb begin : pickSlot
        logic found;
        found = 1'b0;
        freeOneHot = '0;
        for (int i = 0; i < slotCount; i++) begin
            if (!slotBusy[i] && !found) begin
                freeOneHot[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign ready = alive && cooldown == countWidth'(cooldownFrames);
    assign launch = ready ? freeOneHot : '0;

    // the count saturates at the limit until a slot frees up.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cooldown <= '0;
        end else if (|launch) begin
            cooldown <= '0;
        end else if (frameTick && alive && cooldown != countWidth'(cooldownFrames)) begin
            cooldown <= cooldown + 1'b1;
        end
    end

    launchOneHot: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(launch));

endmodule

//--- verilog/missileSlot.sv
module missileSlot #(
    parameter int missileSpeed = 8,
    parameter int launchOffsetX = 30,
    parameter int launchOffsetY = 64
) (
    input  logic clk,
    input  logic rstN,
    input  logic frameTick,
    input  logic launch,
    input  logic slotHit,
    input  logic [bossPkg::coordWidth-1:0] originX,
    input  logic [bossPkg::coordWidth-1:0] originY,
    input  logic [bossPkg::coordWidth-1:0] pixelX,
    input  logic [bossPkg::coordWidth-1:0] pixelY,
    output logic busy,
    output logic slotDraw
);

    localparam int coordWidth = bossPkg::coordWidth;

    logic [coordWidth-1:0] posX;
    logic [coordWidth-1:0] posY;
    logic [coordWidth:0] nextY;
    logic [coordWidth-1:0] offsetX;
    logic [coordWidth-1:0] offsetY;

    assign nextY = {1'b0, posY} + (coordWidth + 1)'(missileSpeed);

    // a hit takes precedence over movement.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else if (launch && !busy) begin
            busy <= 1'b1;
        end else if (slotHit) begin
            busy <= 1'b0;
        end else if (frameTick && busy && nextY >= bossPkg::screenHeight) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (launch && !busy) begin
            posX <= originX + coordWidth'(launchOffsetX);
            posY <= originY + coordWidth'(launchOffsetY);
        end else if (frameTick && busy) begin
            posY <= nextY[coordWidth-1:0];
        end
    end

    assign offsetX = pixelX - posX;
    assign offsetY = pixelY - posY;

    assign slotDraw = busy &&
                      pixelX >= posX && offsetX < bossPkg::missileWidth &&
                      pixelY >= posY && offsetY < bossPkg::missileHeight;

    // the launcher only ever picks a free slot.
    noLaunchWhenBusy: assert property (@(posedge clk) disable iff (!rstN)
        launch |-> !busy);

endmodule

//--- verilog/missileOverlay.sv
module missileOverlay #(
    parameter int slotCount = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic [slotCount-1:0] slotDraw,
    input  logic [6:0] collision,
    output logic missileDR,
    output logic [7:0] missileRGB,
    output logic [slotCount-1:0] slotHit
);

    logic [slotCount-1:0] drawReg;
    logic [slotCount-1:0] firstDraw;
    logic missileHit;

    // registering the requests lines them up with the boss sprite output.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            drawReg <= '0;
        end else begin
            drawReg <= slotDraw;
        end
    end

    assign missileDR = |drawReg;
    assign missileRGB = bossPkg::missileColor;

    // isolate the lowest set bit of the registered requests.
    assign firstDraw = drawReg & (~drawReg + 1'b1);

    assign missileHit = collision[bossPkg::hitMissileBitA] ||
                        collision[bossPkg::hitMissileBitB];

    // collision refers to the registered pixel, so the hit goes back to the slot drawn there.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slotHit <= '0;
        end else begin
            slotHit <= missileHit ? firstDraw : '0;
        end
    end

endmodule

//--- verilog/bossUnit.sv
module bossUnit #(
    parameter int initialX = 300,
    parameter int initialY = 200,
    parameter int xSpeed = 8,
    parameter int ySpeed = -2,
    parameter int deathFrames = 10,
    parameter int cooldownFrames = 90,
    parameter int slotCount = 4,
    parameter int missileSpeed = 8,
    parameter int launchOffsetX = 30,
    parameter int launchOffsetY = 64
) (
    input  logic clk,
    input  logic rstN,
    input  logic enable,
    input  logic startOfFrame,
    input  logic [6:0] collision,
    input  logic [bossPkg::coordWidth-1:0] pixelX,
    input  logic [bossPkg::coordWidth-1:0] pixelY,
    output logic bossDR,
    output logic [7:0] bossRGB,
    output logic missileDR,
    output logic [7:0] missileRGB
);

    logic frameTick;
    logic [bossPkg::coordWidth-1:0] topLeftX;
    logic [bossPkg::coordWidth-1:0] topLeftY;
    logic alive;
    logic visible;
    logic [slotCount-1:0] slotBusy;
    logic [slotCount-1:0] launch;
    logic [slotCount-1:0] slotDraw;
    logic [slotCount-1:0] slotHit;

    // every block steps only on an enabled frame.
    assign frameTick = startOfFrame & enable;

    bossMotion #(
        .initialX(initialX),
        .initialY(initialY),
        .xSpeed(xSpeed),
        .ySpeed(ySpeed),
        .deathFrames(deathFrames)
    ) motion0 (
        .clk(clk),
        .rstN(rstN),
        .frameTick(frameTick),
        .collision(collision),
        .bossDR(bossDR),
        .topLeftX(topLeftX),
        .topLeftY(topLeftY),
        .alive(alive),
        .visible(visible)
    );

    bossSprite sprite0 (
        .clk(clk),
        .rstN(rstN),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .topLeftX(topLeftX),
        .topLeftY(topLeftY),
        .visible(visible),
        .bossDR(bossDR),
        .bossRGB(bossRGB)
    );

    missileLauncher #(
        .slotCount(slotCount),
        .cooldownFrames(cooldownFrames)
    ) launcher0 (
        .clk(clk),
        .rstN(rstN),
        .frameTick(frameTick),
        .alive(alive),
        .slotBusy(slotBusy),
        .launch(launch)
    );

    for (genvar i = 0; i < slotCount; i++) begin : slotGen
        missileSlot #(
            .missileSpeed(missileSpeed),
            .launchOffsetX(launchOffsetX),
            .launchOffsetY(launchOffsetY)
        ) slot (
            .clk(clk),
            .rstN(rstN),
            .frameTick(frameTick),
            .launch(launch[i]),
            .slotHit(slotHit[i]),
            .originX(topLeftX),
            .originY(topLeftY),
            .pixelX(pixelX),
            .pixelY(pixelY),
            .busy(slotBusy[i]),
            .slotDraw(slotDraw[i])
        );
    end

    missileOverlay #(
        .slotCount(slotCount)
    ) overlay0 (
        .clk(clk),
        .rstN(rstN),
        .slotDraw(slotDraw),
        .collision(collision),
        .missileDR(missileDR),
        .missileRGB(missileRGB),
        .slotHit(slotHit)
    );

endmodule

//--- test/clockGen.sv
module clockGen #(
    parameter int periodNs = 10,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2.0) clk = ~clk;
    end

    // reset releases just after a rising edge, in step with the stimulus.
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

//--- test/bossUnitTb.sv
module bossUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int initialX = 300;
    localparam int initialY = 200;
    localparam int xSpeed = 8;
    localparam int ySpeed = -2;
    localparam int deathFrames = 10;
    localparam int cooldownFrames = 90;
    localparam int slotCount = 4;
    localparam int missileSpeed = 8;
    localparam int launchOffsetX = 30;
    localparam int launchOffsetY = 64;
    localparam int maxX = bossPkg::screenWidth - bossPkg::spriteSize;
    localparam int maxY = bossPkg::screenHeight - bossPkg::spriteSize;
    localparam int timeoutCycles = (3 * cooldownFrames + 200) * 20;

    logic clk;
    logic rstN;
    logic enable;
    logic startOfFrame;
    logic [6:0] collision;
    logic [bossPkg::coordWidth-1:0] pixelX;
    logic [bossPkg::coordWidth-1:0] pixelY;
    logic bossDR;
    logic [7:0] bossRGB;
    logic missileDR;
    logic [7:0] missileRGB;

    logic checkOn;
    logic expBossDR;
    logic [7:0] expBossRGB;
    logic expMissileDR;
    int errorCount;
    int probeCount;
    int cycleCount;
    logic [31:0] lcgState;

    // reference model of the boss, the launcher and the missile slots.
    bossPkg::bossStateT modelState;
    int modelX;
    int modelY;
    int velX;
    int velY;
    int dieCount;
    int cooldown;
    logic slotBusyM [slotCount];
    int slotX [slotCount];
    int slotY [slotCount];

    clockGen clock0 (.clk(clk), .rstN(rstN));

    bossUnit #(
        .initialX(initialX), .initialY(initialY),
        .xSpeed(xSpeed), .ySpeed(ySpeed),
        .deathFrames(deathFrames), .cooldownFrames(cooldownFrames),
        .slotCount(slotCount), .missileSpeed(missileSpeed),
        .launchOffsetX(launchOffsetX), .launchOffsetY(launchOffsetY)
    ) dut0 (
        .clk(clk), .rstN(rstN), .enable(enable), .startOfFrame(startOfFrame),
        .collision(collision), .pixelX(pixelX), .pixelY(pixelY),
        .bossDR(bossDR), .bossRGB(bossRGB), .missileDR(missileDR), .missileRGB(missileRGB)
    );

    bossDrCheck: assert property (@(posedge clk) disable iff (!rstN)
        checkOn |-> bossDR == expBossDR) else begin
        errorCount++;
        $display("ERROR bossDR: got %h expected %h at pixel %0d,%0d", $sampled(bossDR),
                 $sampled(expBossDR), $sampled(pixelX), $sampled(pixelY));
    end

    bossRgbCheck: assert property (@(posedge clk) disable iff (!rstN)
        checkOn && expBossDR |-> bossRGB == expBossRGB) else begin
        errorCount++;
        $display("ERROR bossRGB: got %h expected %h", $sampled(bossRGB), $sampled(expBossRGB));
    end

    missileDrCheck: assert property (@(posedge clk) disable iff (!rstN)
        checkOn |-> missileDR == expMissileDR) else begin
        errorCount++;
        $display("ERROR missileDR: got %h expected %h at pixel %0d,%0d", $sampled(missileDR),
                 $sampled(expMissileDR), $sampled(pixelX), $sampled(pixelY));
    end

    missileRgbCheck: assert property (@(posedge clk) disable iff (!rstN)
        checkOn && expMissileDR |-> missileRGB == bossPkg::missileColor) else begin
        errorCount++;
        $display("ERROR missileRGB: got %h expected %h", $sampled(missileRGB),
                 bossPkg::missileColor);
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("run stopped: no end after %0d cycles, %0d errors", cycleCount, errorCount);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic int randomBelow(input int span);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return int'(lcgState[31:16]) % span;
    endfunction

    function automatic logic bossCovers(input int px, input int py);
        return modelState != bossPkg::gone &&
               px >= modelX && px < modelX + bossPkg::spriteSize &&
               py >= modelY && py < modelY + bossPkg::spriteSize;
    endfunction

    // the core is the centred 16x16 square of the box.
    function automatic logic [7:0] bossColorAt(input int px, input int py);
        int low;
        low = (bossPkg::spriteSize - 16) / 2;
        if (px - modelX >= low && px - modelX < low + 16 &&
            py - modelY >= low && py - modelY < low + 16) begin
            return bossPkg::coreColor;
        end
        return bossPkg::bodyColor;
    endfunction

    function automatic int missileAt(input int px, input int py);
        for (int i = 0; i < slotCount; i++) begin
            if (slotBusyM[i] && px >= slotX[i] && px < slotX[i] + bossPkg::missileWidth &&
                py >= slotY[i] && py < slotY[i] + bossPkg::missileHeight) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic stepAxis(inout int pos, inout int vel, input int limit);
        pos = pos + vel;
        if (pos < 0 || pos > limit) begin
            pos = (pos < 0) ? 0 : limit;
            vel = -vel;
        end
    endtask

    task automatic modelFrame();
        if (modelState == bossPkg::alive) begin
            if (cooldown < cooldownFrames) cooldown++;
            stepAxis(modelX, velX, maxX);
            stepAxis(modelY, velY, maxY);
        end else if (modelState == bossPkg::dying) begin
            if (dieCount == deathFrames - 1) modelState = bossPkg::gone;
            else dieCount++;
        end
        for (int i = 0; i < slotCount; i++) begin
            if (slotBusyM[i] && slotY[i] + missileSpeed >= bossPkg::screenHeight) begin
                slotBusyM[i] = 1'b0;
            end else if (slotBusyM[i]) begin
                slotY[i] = slotY[i] + missileSpeed;
            end
        end
    endtask

    task automatic modelLaunch();
        int free;
        free = -1;
        for (int i = slotCount - 1; i >= 0; i--) begin
            if (!slotBusyM[i]) free = i;
        end
        if (modelState == bossPkg::alive && cooldown == cooldownFrames && free >= 0) begin
            slotBusyM[free] = 1'b1;
            slotX[free] = modelX + launchOffsetX;
            slotY[free] = modelY + launchOffsetY;
            cooldown = 0;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // one cycle of startOfFrame, then an idle cycle in which a launch can fire.
    task automatic frameStep();
        startOfFrame = 1'b1;
        nextCycle();
        startOfFrame = 1'b0;
        if (enable) modelFrame();
        nextCycle();
        modelLaunch();
    endtask

    // the collision vector goes out with the registered outputs of the probed pixel.
    task automatic probe(input int x, input int y, input logic [6:0] hit);
        int px;
        int py;
        int slot;
        pixelX = (bossPkg::coordWidth)'(x);
        pixelY = (bossPkg::coordWidth)'(y);
        px = int'(pixelX);
        py = int'(pixelY);
        expBossDR = bossCovers(px, py);
        expBossRGB = bossColorAt(px, py);
        expMissileDR = missileAt(px, py) >= 0;
        nextCycle();
        checkOn = 1'b1;
        collision = hit;
        nextCycle();
        checkOn = 1'b0;
        collision = '0;
        probeCount++;
        if (hit != '0) begin
            slot = missileAt(px, py);
            if ((hit[bossPkg::hitMissileBitA] || hit[bossPkg::hitMissileBitB]) && slot >= 0) begin
                slotBusyM[slot] = 1'b0;
            end
            if (hit[bossPkg::hitBossBit] && expBossDR && modelState == bossPkg::alive) begin
                modelState = bossPkg::dying;
                dieCount = 0;
            end
            nextCycle();
            nextCycle();
            modelLaunch();
        end
    endtask

    task automatic probeBossEdges();
        probe(modelX, modelY, '0);
        probe(modelX - 1, modelY - 1, '0);
        probe(modelX + randomBelow(96) - 16, modelY + randomBelow(96) - 16, '0);
    endtask

    initial begin
        int lastX;
        int lastY;
        enable = 1'b1;
        startOfFrame = 1'b0;
        collision = '0;
        pixelX = '0;
        pixelY = '0;
        checkOn = 1'b0;
        expBossDR = 1'b0;
        expBossRGB = '0;
        expMissileDR = 1'b0;
        errorCount = 0;
        probeCount = 0;
        cycleCount = 0;
        lcgState = 32'hd52ed87c;
        modelState = bossPkg::alive;
        modelX = initialX;
        modelY = initialY;
        velX = xSpeed;
        velY = ySpeed;
        dieCount = 0;
        cooldown = 0;
        for (int i = 0; i < slotCount; i++) begin
            slotBusyM[i] = 1'b0;
            slotX[i] = 0;
            slotY[i] = 0;
        end
        wait (rstN);
        nextCycle();

        probe(modelX + 32, modelY + 32, '0);
        probe(modelX + 3, modelY + 50, '0);
        probe(modelX + 64, modelY + 10, '0);
        probe(modelX + 10, modelY + 64, '0);
        probe(modelX + launchOffsetX + 1, modelY + launchOffsetY + 2, '0);

        // forty steps carry the boss into the right edge and back.
        repeat (40) begin
            frameStep();
            probeBossEdges();
        end

        enable = 1'b0;
        repeat (5) begin
            frameStep();
            probeBossEdges();
        end
        enable = 1'b1;

        while (!slotBusyM[0]) frameStep();
        while (slotBusyM[0]) begin
            lastX = slotX[0];
            lastY = slotY[0];
            probe(lastX + randomBelow(bossPkg::missileWidth),
                  lastY + randomBelow(bossPkg::missileHeight), '0);
            frameStep();
        end
        probe(lastX + 1, lastY + 2, '0);

        for (int k = 0; k < 2; k++) begin
            while (!slotBusyM[0]) frameStep();
            lastX = slotX[0] + 2;
            lastY = slotY[0] + 3;
            probe(lastX, lastY, (k == 0) ? 7'(1 << bossPkg::hitMissileBitA) :
                                           7'(1 << bossPkg::hitMissileBitB));
            probe(lastX, lastY, '0);
        end

        // after the boss hit it stays put and launches nothing, and it vanishes after the delay.
        probe(modelX + 20, modelY + 20, 7'(1 << bossPkg::hitBossBit));
        repeat (deathFrames + cooldownFrames + 10) begin
            frameStep();
            probeBossEdges();
            probe(modelX + launchOffsetX + 1, modelY + launchOffsetY + 1, '0);
        end

        nextCycle();
        $display("probes: %0d, errors: %0d", probeCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/bossPkg.sv
verilog/bossMotion.sv
verilog/bossSprite.sv
verilog/missileLauncher.sv
verilog/missileSlot.sv
verilog/missileOverlay.sv
verilog/bossUnit.sv
test/clockGen.sv
test/bossUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= bossUnitTb
FLAGS ?= --assert -Wno-fatal
BUILD_DIR ?= obj_dir
PASS_TEXT ?= All tests passed

SOURCES := $(wildcard verilog/*.sv test/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): compile.f $(SOURCES)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f

run: $(BUILD_DIR)/V$(TOP)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf $(BUILD_DIR)
